//--- common/soc_cfg.svh
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// bus widths
`define ALEN 32
`define XLEN 32

// sram size in kilobytes
`define SRAM_KB 8

// memory map, decoded by the top REGION_BITS address bits
`define SRAM_BASE 32'h0000_0000
`define GPIO_BASE 32'h1000_0000
`define REGION_BITS 4

`endif

//--- common/axil_pkg.sv
`include "soc_cfg.svh"

package axil_pkg;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    typedef struct packed {
        logic [`ALEN-1:0] addr;
        logic [2:0]       prot;
    } aw_t;

    // read address carries the same fields
    typedef aw_t ar_t;

    typedef struct packed {
        logic [`XLEN-1:0]   data;
        logic [`XLEN/8-1:0] strb;
    } w_t;

    typedef struct packed {
        logic [1:0] resp;
    } b_t;

    typedef struct packed {
        logic [`XLEN-1:0] data;
        logic [1:0]       resp;
    } r_t;

    // master to slave
    typedef struct packed {
        aw_t  aw;
        logic awvalid;
        w_t   w;
        logic wvalid;
        logic bready;
        ar_t  ar;
        logic arvalid;
        logic rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic awready;
        logic wready;
        b_t   b;
        logic bvalid;
        logic arready;
        r_t   r;
        logic rvalid;
    } axil_rsp_t;

endpackage

//--- common/soc_pkg.sv
`include "soc_cfg.svh"

package soc_pkg;

    // values double as crossbar slave indices
    typedef enum logic [1:0] {
        SEL_SRAM = 2'd0,
        SEL_GPIO = 2'd1,
        SEL_NONE = 2'd2
    } dev_sel_e;

    localparam logic [`REGION_BITS-1:0] SRAM_REGION =
        `REGION_BITS'(`SRAM_BASE >> (`ALEN - `REGION_BITS));
    localparam logic [`REGION_BITS-1:0] GPIO_REGION =
        `REGION_BITS'(`GPIO_BASE >> (`ALEN - `REGION_BITS));

    function automatic dev_sel_e decode_addr(input logic [`ALEN-1:0] addr);
        logic [`REGION_BITS-1:0] region;
        region = addr[`ALEN-1 -: `REGION_BITS];
        if (region == SRAM_REGION) begin
            return SEL_SRAM;
        end
        if (region == GPIO_REGION) begin
            return SEL_GPIO;
        end
        return SEL_NONE;
    endfunction

endpackage

//--- axilxbar/axil_skid.sv
`timescale 1ns/100ps

module axil_skid #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     skid_valid;
    logic     skid_valid_d;
    payload_t skid_data;
    logic     in_xfer;
    logic     out_free;

    assign in_xfer  = in_valid && in_ready;
    assign out_free = out_ready || !out_valid;

    // second entry only fills while the output stage is stalled
    assign skid_valid_d = out_free ? 1'b0 : (skid_valid || in_xfer);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            if (out_free) begin
                out_valid <= skid_valid || in_xfer;
            end
            skid_valid <= skid_valid_d;
            in_ready   <= !skid_valid_d;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_data <= skid_valid ? skid_data : in_data;
        end
        if (!out_free && in_xfer) begin
            skid_data <= in_data;
        end
    end

endmodule

//--- axilxbar/axilxbar.sv
`timescale 1ns/100ps

module axilxbar import axil_pkg::*, soc_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,

    input  axil_req_t m_req [2],
    output axil_rsp_t m_rsp [2],

    output axil_req_t s_req [2],
    input  axil_rsp_t s_rsp [2]
);

    localparam int NM  = 2;
    localparam int ERR = int'(SEL_NONE);
    localparam int NS  = ERR + 1;

    aw_t       sk_aw       [NM];
    w_t        sk_w        [NM];
    ar_t       sk_ar       [NM];
    logic      sk_aw_valid [NM];
    logic      sk_w_valid  [NM];
    logic      sk_ar_valid [NM];
    logic      sk_aw_ready [NM];
    logic      sk_w_ready  [NM];
    logic      sk_ar_ready [NM];
    logic      aw_in_ready [NM];
    logic      w_in_ready  [NM];
    logic      ar_in_ready [NM];
    dev_sel_e  aw_sel      [NM];
    dev_sel_e  ar_sel      [NM];

    logic [NM-1:0] wr_req [NS];
    logic [NM-1:0] rd_req [NS];
    logic [NS-1:0] wr_busy, wr_owner, wr_prio, wr_act, wr_own, aw_done, w_done;
    logic [NS-1:0] rd_busy, rd_owner, rd_prio, rd_act, rd_own, ar_done;

    axil_req_t x_req [NS];
    axil_rsp_t x_rsp [NS];
    axil_rsp_t err_rsp;
    logic      err_aw_got, err_w_got, err_ar_got, err_bvalid, err_rvalid;

    function automatic logic rr_pick(input logic [NM-1:0] req, input logic prio);
        return req[prio] ? prio : ~prio;
    endfunction

    for (genvar m = 0; m < NM; m++) begin : g_master
        axil_skid #(.payload_t(aw_t)) aw_skid (
            .clk, .arst_n,
            .in_valid(m_req[m].awvalid), .in_ready(aw_in_ready[m]), .in_data(m_req[m].aw),
            .out_valid(sk_aw_valid[m]), .out_ready(sk_aw_ready[m]), .out_data(sk_aw[m])
        );
        axil_skid #(.payload_t(w_t)) w_skid (
            .clk, .arst_n,
            .in_valid(m_req[m].wvalid), .in_ready(w_in_ready[m]), .in_data(m_req[m].w),
            .out_valid(sk_w_valid[m]), .out_ready(sk_w_ready[m]), .out_data(sk_w[m])
        );
        axil_skid #(.payload_t(ar_t)) ar_skid (
            .clk, .arst_n,
            .in_valid(m_req[m].arvalid), .in_ready(ar_in_ready[m]), .in_data(m_req[m].ar),
            .out_valid(sk_ar_valid[m]), .out_ready(sk_ar_ready[m]), .out_data(sk_ar[m])
        );
        assign aw_sel[m] = decode_addr(sk_aw[m].addr);
        assign ar_sel[m] = decode_addr(sk_ar[m].addr);
    end

    assign s_req[0] = x_req[0];
    assign s_req[1] = x_req[1];
    assign x_rsp[0] = s_rsp[0];
    assign x_rsp[1] = s_rsp[1];
    assign x_rsp[ERR] = err_rsp;

    // arbitration, an idle slave grants in the same cycle
    always_comb begin
        for (int s = 0; s < NS; s++) begin
            for (int m = 0; m < NM; m++) begin
                wr_req[s][m] = sk_aw_valid[m] && (int'(aw_sel[m]) == s);
                rd_req[s][m] = sk_ar_valid[m] && (int'(ar_sel[m]) == s);
            end
            wr_act[s] = wr_busy[s] || (|wr_req[s]);
            rd_act[s] = rd_busy[s] || (|rd_req[s]);
            wr_own[s] = wr_busy[s] ? wr_owner[s] : rr_pick(wr_req[s], wr_prio[s]);
            rd_own[s] = rd_busy[s] ? rd_owner[s] : rr_pick(rd_req[s], rd_prio[s]);
        end
    end

    always_comb begin
        for (int s = 0; s < NS; s++) begin
            x_req[s] = '0;
            x_req[s].aw      = sk_aw[wr_own[s]];
            x_req[s].awvalid = wr_act[s] && sk_aw_valid[wr_own[s]] && !aw_done[s];
            x_req[s].w       = sk_w[wr_own[s]];
            x_req[s].wvalid  = wr_act[s] && sk_w_valid[wr_own[s]] && !w_done[s];
            x_req[s].bready  = wr_busy[s] && m_req[wr_own[s]].bready;
            x_req[s].ar      = sk_ar[rd_own[s]];
            x_req[s].arvalid = rd_act[s] && sk_ar_valid[rd_own[s]] && !ar_done[s];
            x_req[s].rready  = rd_busy[s] && m_req[rd_own[s]].rready;
        end
    end

    // steer readies and responses back to the granted master
    always_comb begin
        for (int m = 0; m < NM; m++) begin
            sk_aw_ready[m]   = 1'b0;
            sk_w_ready[m]    = 1'b0;
            sk_ar_ready[m]   = 1'b0;
            m_rsp[m]         = '0;
            m_rsp[m].awready = aw_in_ready[m];
            m_rsp[m].wready  = w_in_ready[m];
            m_rsp[m].arready = ar_in_ready[m];
        end
        for (int s = 0; s < NS; s++) begin
            if (wr_act[s]) begin
                sk_aw_ready[wr_own[s]] = x_rsp[s].awready && !aw_done[s];
                sk_w_ready[wr_own[s]]  = x_rsp[s].wready && !w_done[s];
            end
            if (wr_busy[s]) begin
                m_rsp[wr_own[s]].b      = x_rsp[s].b;
                m_rsp[wr_own[s]].bvalid = x_rsp[s].bvalid;
            end
            if (rd_act[s]) begin
                sk_ar_ready[rd_own[s]] = x_rsp[s].arready && !ar_done[s];
            end
            if (rd_busy[s]) begin
                m_rsp[rd_own[s]].r      = x_rsp[s].r;
                m_rsp[rd_own[s]].rvalid = x_rsp[s].rvalid;
            end
        end
    end

    // grant held until the response handshake
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_busy  <= '0;
            wr_owner <= '0;
            wr_prio  <= '0;
            aw_done  <= '0;
            w_done   <= '0;
            rd_busy  <= '0;
            rd_owner <= '0;
            rd_prio  <= '0;
            ar_done  <= '0;
        end else begin
            for (int s = 0; s < NS; s++) begin
                if (wr_act[s]) begin
                    wr_busy[s]  <= 1'b1;
                    wr_owner[s] <= wr_own[s];
                    if (x_req[s].awvalid && x_rsp[s].awready) aw_done[s] <= 1'b1;
                    if (x_req[s].wvalid && x_rsp[s].wready) w_done[s] <= 1'b1;
                    if (x_rsp[s].bvalid && x_req[s].bready) begin
                        wr_busy[s] <= 1'b0;
                        aw_done[s] <= 1'b0;
                        w_done[s]  <= 1'b0;
                        wr_prio[s] <= ~wr_own[s];
                    end
                end
                if (rd_act[s]) begin
                    rd_busy[s]  <= 1'b1;
                    rd_owner[s] <= rd_own[s];
                    if (x_req[s].arvalid && x_rsp[s].arready) ar_done[s] <= 1'b1;
                    if (x_rsp[s].rvalid && x_req[s].rready) begin
                        rd_busy[s] <= 1'b0;
                        ar_done[s] <= 1'b0;
                        rd_prio[s] <= ~rd_own[s];
                    end
                end
            end
        end
    end

    // decode error responder for unmapped addresses
    always_comb begin
        err_rsp         = '0;
        err_rsp.awready = !err_aw_got && !err_bvalid;
        err_rsp.wready  = !err_w_got && !err_bvalid;
        err_rsp.b.resp  = RESP_DECERR;
        err_rsp.bvalid  = err_bvalid;
        err_rsp.arready = !err_ar_got && !err_rvalid;
        err_rsp.r.data  = '0;
        err_rsp.r.resp  = RESP_DECERR;
        err_rsp.rvalid  = err_rvalid;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            err_aw_got <= 1'b0;
            err_w_got  <= 1'b0;
            err_ar_got <= 1'b0;
            err_bvalid <= 1'b0;
            err_rvalid <= 1'b0;
        end else begin
            if (x_req[ERR].awvalid && err_rsp.awready) err_aw_got <= 1'b1;
            if (x_req[ERR].wvalid && err_rsp.wready) err_w_got <= 1'b1;
            if (err_aw_got && err_w_got) begin
                err_aw_got <= 1'b0;
                err_w_got  <= 1'b0;
                err_bvalid <= 1'b1;
            end else if (err_bvalid && x_req[ERR].bready) begin
                err_bvalid <= 1'b0;
            end
            if (x_req[ERR].arvalid && err_rsp.arready) err_ar_got <= 1'b1;
            if (err_ar_got) begin
                err_ar_got <= 1'b0;
                err_rvalid <= 1'b1;
            end else if (err_rvalid && x_req[ERR].rready) begin
                err_rvalid <= 1'b0;
            end
        end
    end

endmodule

//--- verilog/axil_sram.sv
`timescale 1ns/100ps
`include "soc_cfg.svh"

module axil_sram import axil_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  axil_req_t req,
    output axil_rsp_t rsp
);

    localparam int WORDS = `SRAM_KB * 256;
    localparam int IDX_W = $clog2(WORDS);

    logic [`XLEN-1:0] mem [WORDS];

    logic             aw_got, w_got, bvalid, rvalid;
    logic [`ALEN-1:0] aw_addr;
    w_t               w_q;
    logic [`XLEN-1:0] r_data;
    logic             aw_xfer, w_xfer, ar_xfer, wr_fire;
    logic [`ALEN-1:0] wr_addr;
    w_t               wr_w;
    logic [IDX_W-1:0] wr_idx, rd_idx;

    always_comb begin
        rsp         = '0;
        rsp.awready = !aw_got && !bvalid;
        rsp.wready  = !w_got && !bvalid;
        rsp.b.resp  = RESP_OKAY;
        rsp.bvalid  = bvalid;
        rsp.arready = !rvalid;
        rsp.r.data  = r_data;
        rsp.r.resp  = RESP_OKAY;
        rsp.rvalid  = rvalid;
    end

    assign aw_xfer = req.awvalid && rsp.awready;
    assign w_xfer  = req.wvalid && rsp.wready;
    assign ar_xfer = req.arvalid && rsp.arready;

    // write goes ahead once both halves are in, held or arriving
    assign wr_addr = aw_got ? aw_addr : req.aw.addr;
    assign wr_w    = w_got ? w_q : req.w;
    assign wr_fire = (aw_got || aw_xfer) && (w_got || w_xfer) && !bvalid;

    // upper bits ignored, so the region aliases
    assign wr_idx = wr_addr[IDX_W+1:2];
    assign rd_idx = req.ar.addr[IDX_W+1:2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_fire) begin
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                bvalid <= 1'b1;
            end else begin
                if (aw_xfer) aw_got <= 1'b1;
                if (w_xfer) w_got <= 1'b1;
                if (bvalid && req.bready) bvalid <= 1'b0;
            end
            if (ar_xfer) begin
                rvalid <= 1'b1;
            end else if (rvalid && req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_xfer) aw_addr <= req.aw.addr;
        if (w_xfer) w_q <= req.w;
        if (ar_xfer) r_data <= mem[rd_idx];
        if (wr_fire) begin
            for (int i = 0; i < `XLEN/8; i++) begin
                if (wr_w.strb[i]) mem[wr_idx][8*i +: 8] <= wr_w.data[8*i +: 8];
            end
        end
    end

endmodule

//--- verilog/axil_gpio.sv
`timescale 1ns/100ps
`include "soc_cfg.svh"

module axil_gpio import axil_pkg::*; #(
    parameter int NUM_OUTPUTS = 4
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  axil_req_t              req,
    output axil_rsp_t              rsp,
    output logic [NUM_OUTPUTS-1:0] outputs
);

    // offset bits inside the gpio region
    localparam int OFS_W = `ALEN - `REGION_BITS;

    logic                   aw_got, w_got, bvalid, rvalid;
    logic [`ALEN-1:0]       aw_addr;
    w_t                     w_q;
    logic [`XLEN-1:0]       r_data;
    logic [NUM_OUTPUTS-1:0] out_q;
    logic                   aw_xfer, w_xfer, ar_xfer, wr_fire;
    logic [`ALEN-1:0]       wr_addr;
    w_t                     wr_w;
    logic                   wr_reg, rd_reg;
    logic [`XLEN-1:0]       merged;

    always_comb begin
        rsp         = '0;
        rsp.awready = !aw_got && !bvalid;
        rsp.wready  = !w_got && !bvalid;
        rsp.b.resp  = RESP_OKAY;
        rsp.bvalid  = bvalid;
        rsp.arready = !rvalid;
        rsp.r.data  = r_data;
        rsp.r.resp  = RESP_OKAY;
        rsp.rvalid  = rvalid;
    end

    assign aw_xfer = req.awvalid && rsp.awready;
    assign w_xfer  = req.wvalid && rsp.wready;
    assign ar_xfer = req.arvalid && rsp.arready;

    assign wr_addr = aw_got ? aw_addr : req.aw.addr;
    assign wr_w    = w_got ? w_q : req.w;
    assign wr_fire = (aw_got || aw_xfer) && (w_got || w_xfer) && !bvalid;
    assign wr_reg  = (wr_addr[OFS_W-1:2] == '0);
    assign rd_reg  = (req.ar.addr[OFS_W-1:2] == '0);

    always_comb begin
        merged = `XLEN'(out_q);
        for (int i = 0; i < `XLEN/8; i++) begin
            if (wr_w.strb[i]) merged[8*i +: 8] = wr_w.data[8*i +: 8];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            out_q  <= '0;
        end else begin
            if (wr_fire) begin
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                bvalid <= 1'b1;
                // pins move on the edge that raises bvalid
                if (wr_reg) out_q <= merged[NUM_OUTPUTS-1:0];
            end else begin
                if (aw_xfer) aw_got <= 1'b1;
                if (w_xfer) w_got <= 1'b1;
                if (bvalid && req.bready) bvalid <= 1'b0;
            end
            if (ar_xfer) begin
                rvalid <= 1'b1;
            end else if (rvalid && req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_xfer) aw_addr <= req.aw.addr;
        if (w_xfer) w_q <= req.w;
        if (ar_xfer) r_data <= rd_reg ? `XLEN'(out_q) : '0;
    end

    assign outputs = out_q;

endmodule

//--- verilog/basic_soc.sv
`timescale 1ns/100ps

module basic_soc import axil_pkg::*; #(
    parameter int GPIO_OUTPUTS = 4
) (
    input  logic                    clk,
    input  logic                    arst_n,

    // instruction fetch master
    input  axil_req_t               ifetch_req,
    output axil_rsp_t               ifetch_rsp,

    // data master
    input  axil_req_t               data_req,
    output axil_rsp_t               data_rsp,

    output logic [GPIO_OUTPUTS-1:0] gpio_outputs
);

    axil_req_t m_req [2];
    axil_rsp_t m_rsp [2];
    axil_req_t s_req [2];
    axil_rsp_t s_rsp [2];

    assign m_req[0]   = ifetch_req;
    assign m_req[1]   = data_req;
    assign ifetch_rsp = m_rsp[0];
    assign data_rsp   = m_rsp[1];

    axilxbar sys_bus (
        .clk,
        .arst_n,
        .m_req,
        .m_rsp,
        .s_req,
        .s_rsp
    );

    // slave 0
    axil_sram axil_sram (
        .clk,
        .arst_n,
        .req(s_req[0]),
        .rsp(s_rsp[0])
    );

    // slave 1
    axil_gpio #(
        .NUM_OUTPUTS(GPIO_OUTPUTS)
    ) axil_gpio (
        .clk,
        .arst_n,
        .req(s_req[1]),
        .rsp(s_rsp[1]),
        .outputs(gpio_outputs)
    );

endmodule

//--- bench/basic_soc_sva.sv
`timescale 1ns/100ps

module basic_soc_sva import axil_pkg::*; #(
    parameter int GPIO_OUTPUTS = 4
) (
    input logic                    clk,
    input logic                    arst_n,
    input axil_req_t               ifetch_req,
    input axil_rsp_t               ifetch_rsp,
    input axil_req_t               data_req,
    input axil_rsp_t               data_rsp,
    input logic [GPIO_OUTPUTS-1:0] gpio_outputs
);

    axil_req_t req [2];
    axil_rsp_t rsp [2];

    assign req[0] = ifetch_req;
    assign req[1] = data_req;
    assign rsp[0] = ifetch_rsp;
    assign rsp[1] = data_rsp;

    for (genvar m = 0; m < 2; m++) begin : g_port
        a_aw_hold: assert property (@(posedge clk) disable iff (!arst_n)
            req[m].awvalid && !rsp[m].awready |=> req[m].awvalid && $stable(req[m].aw))
            else $error("aw dropped or changed before awready on port %0d", m);
        a_w_hold: assert property (@(posedge clk) disable iff (!arst_n)
            req[m].wvalid && !rsp[m].wready |=> req[m].wvalid && $stable(req[m].w))
            else $error("w dropped or changed before wready on port %0d", m);
        a_ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
            req[m].arvalid && !rsp[m].arready |=> req[m].arvalid && $stable(req[m].ar))
            else $error("ar dropped or changed before arready on port %0d", m);
        a_b_hold: assert property (@(posedge clk) disable iff (!arst_n)
            rsp[m].bvalid && !req[m].bready |=> rsp[m].bvalid && $stable(rsp[m].b))
            else $error("b dropped or changed before bready on port %0d", m);
        a_r_hold: assert property (@(posedge clk) disable iff (!arst_n)
            rsp[m].rvalid && !req[m].rready |=> rsp[m].rvalid && $stable(rsp[m].r))
            else $error("r dropped or changed before rready on port %0d", m);
    end

    a_rst_valid: assert property (@(posedge clk) !arst_n |->
        !ifetch_rsp.bvalid && !ifetch_rsp.rvalid && !data_rsp.bvalid && !data_rsp.rvalid)
        else $error("response valid high during reset");

    a_rst_gpio: assert property (@(posedge clk) !arst_n |-> gpio_outputs == '0)
        else $error("gpio outputs not cleared during reset");

endmodule

bind basic_soc basic_soc_sva #(
    .GPIO_OUTPUTS(GPIO_OUTPUTS)
) u_sva (
    .clk(clk),
    .arst_n(arst_n),
    .ifetch_req(ifetch_req),
    .ifetch_rsp(ifetch_rsp),
    .data_req(data_req),
    .data_rsp(data_rsp),
    .gpio_outputs(gpio_outputs)
);

//--- bench/basic_soc_tb.sv
`timescale 1ns/100ps
`include "soc_cfg.svh"

module basic_soc_tb import axil_pkg::*, soc_pkg::*; ();

    localparam int GPIO_OUTPUTS = 4;
    localparam int SRAM_WORDS   = `SRAM_KB * 256;
    localparam int SRAM_BYTES   = `SRAM_KB * 1024;
    localparam int INIT_OPS     = 128;
    localparam int STRB_OPS     = 32;
    localparam int XFER_OPS     = 16;
    localparam int MIX_OPS      = 64;
    localparam int N_OPS        = INIT_OPS + 2 * STRB_OPS + 2 * XFER_OPS + 13 + 2 * MIX_OPS;
    localparam int LIMIT_CYCLES = 16 + N_OPS * 40;

    // word offset bits inside a region
    localparam logic [`ALEN-1:0] GPIO_WORD_MASK =
        {{`REGION_BITS{1'b0}}, {(`ALEN - `REGION_BITS - 2){1'b1}}, 2'b00};

    logic                    clk;
    logic                    arst_n;
    axil_req_t               mreq [2];
    axil_rsp_t               mrsp [2];
    logic [GPIO_OUTPUTS-1:0] gpio_outputs;

    integer seed = 86;

    // model state and expected responses per master
    logic [`XLEN-1:0]        ref_mem [SRAM_WORDS];
    logic [GPIO_OUTPUTS-1:0] ref_gpio;
    r_t                      exp_rd [2][$];
    b_t                      exp_wr [2][$];

    basic_soc #(
        .GPIO_OUTPUTS(GPIO_OUTPUTS)
    ) u_basic_soc (
        .clk(clk),
        .arst_n(arst_n),
        .ifetch_req(mreq[0]),
        .ifetch_rsp(mrsp[0]),
        .data_req(mreq[1]),
        .data_rsp(mrsp[1]),
        .gpio_outputs(gpio_outputs)
    );

    always #4 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input logic [63:0] got, input logic [63:0] expected,
                         input string what);
        if (got !== expected) begin
            fail_run($sformatf("Mismatch at %0t ns: %s, got %h, expected %h",
                               $time, what, got, expected));
        end
    endtask

    function automatic w_t wbeat(input logic [`XLEN-1:0] data,
                                 input logic [`XLEN/8-1:0] strb);
        w_t beat;
        beat.data = data;
        beat.strb = strb;
        return beat;
    endfunction

    function automatic logic [`XLEN-1:0] merge_bytes(input logic [`XLEN-1:0] old,
                                                     input w_t w);
        logic [`XLEN-1:0] res;
        res = old;
        for (int i = 0; i < `XLEN/8; i++) begin
            if (w.strb[i]) res[8*i +: 8] = w.data[8*i +: 8];
        end
        return res;
    endfunction

    // random alias of a word somewhere in the sram region
    function automatic logic [`ALEN-1:0] sram_addr(input int word);
        return `ALEN'(word * 4 + ($random(seed) & 15) * SRAM_BYTES);
    endfunction

    function automatic r_t ref_access(input logic wr, input logic [`ALEN-1:0] addr,
                                      input w_t w);
        r_t res;
        int idx;
        res.data = '0;
        res.resp = RESP_OKAY;
        case (decode_addr(addr))
            SEL_SRAM: begin
                idx = int'((addr >> 2) % SRAM_WORDS);
                if (wr) ref_mem[idx] = merge_bytes(ref_mem[idx], w);
                else res.data = ref_mem[idx];
            end
            SEL_GPIO: begin
                if ((addr & GPIO_WORD_MASK) == '0) begin
                    if (wr) ref_gpio = GPIO_OUTPUTS'(merge_bytes(`XLEN'(ref_gpio), w));
                    else res.data = `XLEN'(ref_gpio);
                end
            end
            default: res.resp = RESP_DECERR;
        endcase
        return res;
    endfunction

    // one transaction on master m until its response handshake
    task automatic bus_op(input int m, input logic wr, input logic [`ALEN-1:0] addr,
                          input w_t w, input logic stall);
        r_t   expected;
        logic aw_pend;
        logic w_pend;
        logic ar_pend;
        logic rsp_pend;
        logic hold;
        expected = ref_access(wr, addr, w);
        if (wr) begin
            exp_wr[m].push_back(b_t'(expected.resp));
            mreq[m].aw.addr <= addr;
            mreq[m].aw.prot <= 3'b000;
            mreq[m].w       <= w;
        end else begin
            exp_rd[m].push_back(expected);
            mreq[m].ar.addr <= addr;
            mreq[m].ar.prot <= 3'b000;
        end
        mreq[m].awvalid <= wr;
        mreq[m].wvalid  <= wr;
        mreq[m].arvalid <= !wr;
        aw_pend  = wr;
        w_pend   = wr;
        ar_pend  = !wr;
        rsp_pend = 1'b1;
        while (rsp_pend) begin
            @(posedge clk);
            if (aw_pend && mrsp[m].awready) begin
                aw_pend = 1'b0;
                mreq[m].awvalid <= 1'b0;
            end
            if (w_pend && mrsp[m].wready) begin
                w_pend = 1'b0;
                mreq[m].wvalid <= 1'b0;
            end
            if (ar_pend && mrsp[m].arready) begin
                ar_pend = 1'b0;
                mreq[m].arvalid <= 1'b0;
            end
            if (wr && mrsp[m].bvalid && mreq[m].bready) rsp_pend = 1'b0;
            if (!wr && mrsp[m].rvalid && mreq[m].rready) rsp_pend = 1'b0;
            hold = stall && (($random(seed) & 1) == 0);
            mreq[m].bready <= wr && rsp_pend && !hold;
            mreq[m].rready <= !wr && rsp_pend && !hold;
        end
    endtask

    always @(posedge clk) begin
        r_t rd_exp;
        b_t wr_exp;
        for (int m = 0; m < 2; m++) begin
            if (mrsp[m].rvalid && mreq[m].rready) begin
                if (exp_rd[m].size() == 0) begin
                    fail_run($sformatf("master %0d got a read response with no read pending",
                                       m));
                end else begin
                    rd_exp = exp_rd[m].pop_front();
                    check(64'(mrsp[m].r), 64'(rd_exp), $sformatf("read on master %0d", m));
                end
            end
            if (mrsp[m].bvalid && mreq[m].bready) begin
                if (exp_wr[m].size() == 0) begin
                    fail_run($sformatf("master %0d got a write response with no write pending",
                                       m));
                end else begin
                    wr_exp = exp_wr[m].pop_front();
                    check(64'(mrsp[m].b), 64'(wr_exp), $sformatf("write on master %0d", m));
                end
            end
        end
    end

    initial begin
        int idx;
        clk      = 1'b0;
        arst_n   = 1'b0;
        mreq[0]  = '0;
        mreq[1]  = '0;
        ref_gpio = '0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        // defined contents for the words used below
        for (int i = 0; i < INIT_OPS; i++) begin
            bus_op(1, 1'b1, `ALEN'(4 * i), wbeat($random(seed), 4'hf), 1'b0);
        end

        for (int i = 0; i < STRB_OPS; i++) begin
            idx = $random(seed) & 63;
            bus_op(1, 1'b1, sram_addr(idx), wbeat($random(seed), 4'($random(seed))), 1'b0);
            bus_op(1, 1'b0, sram_addr(idx), '0, 1'b0);
        end

        // written by data and read back by ifetch
        for (int i = 0; i < XFER_OPS; i++) begin
            idx = 64 + ($random(seed) & 63);
            bus_op(1, 1'b1, sram_addr(idx), wbeat($random(seed), 4'hf), 1'b0);
            bus_op(0, 1'b0, sram_addr(idx), '0, 1'b0);
        end

        // low nibble has both set and clear bits
        bus_op(1, 1'b1, `GPIO_BASE, wbeat(32'h5a5a_5a5a, 4'hf), 1'b0);
        check(64'(gpio_outputs), 64'(ref_gpio), "gpio pins after write");
        bus_op(1, 1'b0, `GPIO_BASE, '0, 1'b0);
        // upper lanes only so the pins hold
        bus_op(1, 1'b1, `GPIO_BASE, wbeat(32'hffff_ffff, 4'b1110), 1'b0);
        check(64'(gpio_outputs), 64'(ref_gpio), "gpio pins after upper lane write");
        bus_op(1, 1'b1, `GPIO_BASE + 32'h10, wbeat(32'hffff_ffff, 4'hf), 1'b0);
        check(64'(gpio_outputs), 64'(ref_gpio), "gpio pins after other offset write");
        bus_op(1, 1'b0, `GPIO_BASE + 32'h10, '0, 1'b0);
        bus_op(0, 1'b0, `GPIO_BASE, '0, 1'b0);

        // unmapped regions and then reads to confirm nothing moved
        bus_op(1, 1'b1, 32'h3000_0014, wbeat(32'hdead_beef, 4'hf), 1'b0);
        bus_op(1, 1'b0, 32'h3000_0014, '0, 1'b0);
        bus_op(0, 1'b0, 32'hf000_0000, '0, 1'b0);
        bus_op(0, 1'b1, 32'h2000_0000, wbeat(32'hffff_ffff, 4'hf), 1'b0);
        bus_op(1, 1'b0, 32'h0000_0014, '0, 1'b0);
        bus_op(1, 1'b0, 32'h0000_0000, '0, 1'b0);
        bus_op(1, 1'b0, `GPIO_BASE, '0, 1'b0);
        check(64'(gpio_outputs), 64'(ref_gpio), "gpio pins after unmapped writes");

        // ifetch stays on words 64..127 while data writes only 0..63
        fork
            for (int i = 0; i < MIX_OPS; i++) begin
                bus_op(0, 1'b0, sram_addr(64 + ($random(seed) & 63)), '0, 1'b1);
            end
            for (int j = 0; j < MIX_OPS; j++) begin
                bus_op(1, 1'($random(seed) & 1), sram_addr($random(seed) & 63),
                       wbeat($random(seed), 4'($random(seed))), 1'b1);
            end
        join

        repeat (8) @(posedge clk);
        if (exp_rd[0].size() + exp_rd[1].size() + exp_wr[0].size() + exp_wr[1].size() == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            fail_run("responses still pending at the end of the run");
        end
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        fail_run($sformatf("timeout after %0d cycles, a transaction never finished",
                           LIMIT_CYCLES));
    end

endmodule

//--- compile.f
+incdir+common
common/axil_pkg.sv
common/soc_pkg.sv
axilxbar/axil_skid.sv
axilxbar/axilxbar.sv
verilog/axil_sram.sv
verilog/axil_gpio.sv
verilog/basic_soc.sv
bench/basic_soc_sva.sv
bench/basic_soc_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the basic_soc testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module basic_soc_tb --Mdir obj_dir -o basic_soc_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/basic_soc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
    exit 1
fi
exit 0
